/* build.f */
common/motorPkg.sv
hw/stepSequencer.sv
pwm/pwmGenerator.sv
hw/motorRegs.sv
hw/motorDrive.sv
testbench/motorDrive_chk.sv
testbench/motorDriveTb.sv

/* Makefile */
# Verilator build and run for the motor PWM drive

SIM     ?= verilator
TOP     ?= motorDriveTb
VFLAGS  ?= --binary --timing --assert
OBJ_DIR ?= obj_dir
FILELIST ?= build.f

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) -f $(FILELIST) --top-module $* -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/motorDriveTb.sv */
`timescale 1ns/1ps

module motorDriveTb;

    logic                          clk;
    logic                          arstN;
    logic                          wrEn;
    logic [motorPkg::ADDR_W-1:0]   addr;
    logic [motorPkg::DATA_W-1:0]   wrData;
    logic [motorPkg::DATA_W-1:0]   rdData;
    logic                          pwmA;
    logic                          pwmB;
    logic                          pwmC;
    logic [motorPkg::STEP_W-1:0]   stepIdx;

    int          mismatches = 0;
    int          otherErrors = 0;
    int          cycleCnt = 0;
    int          hiCnt [3];
    int          riseCnt [3];
    logic [31:0] lfsr = 32'hb3ba;

    motorDrive i_motorDrive (
        .clk, .arstN, .wrEn, .addr, .wrData, .rdData,
        .pwmA, .pwmB, .pwmC, .stepIdx
    );

    always #50 clk = ~clk;

    always @(posedge clk) cycleCnt++;

    // galois LFSR, one shift per bit handed out
    function automatic logic [15:0] randomBits(input int n);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[14:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return val;
    endfunction

    task automatic writeReg(input logic [2:0] a, input int d);
        @(posedge clk);
        #5;
        wrEn   = 1'b1;
        addr   = a;
        wrData = motorPkg::DATA_W'(d);
        @(posedge clk);
        #5;
        wrEn = 1'b0;
    endtask

    task automatic readCheck(input logic [2:0] a, input int expected);
        @(posedge clk);
        #5;
        addr = a;
        @(negedge clk);
        if (rdData != expected[motorPkg::DATA_W-1:0]) begin
            $display("MISMATCH at %0t: address %0d read %0d, expected %0d",
                     $time, a, rdData, expected);
            mismatches++;
        end
    endtask

    task automatic waitStepChange();
        logic [3:0] startIdx;
        bit         seen;
        startIdx = stepIdx;
        seen     = 0;
        for (int n = 0; n < 30000 && !seen; n++) begin
            @(negedge clk);
            seen = (stepIdx != startIdx);
        end
        if (!seen) begin
            $display("timeout: the step index did not advance");
            otherErrors++;
        end
    endtask

    // counts high cycles and rises per phase until the step index changes
    task automatic measureStep();
        logic [3:0] idx;
        logic [2:0] prev;
        logic [2:0] cur;
        bit         done;
        idx  = stepIdx;
        prev = {pwmC, pwmB, pwmA};
        done = 0;
        for (int p = 0; p < 3; p++) begin
            hiCnt[p]   = int'(prev[p]);
            riseCnt[p] = 0;
        end
        for (int n = 0; n < 30000 && !done; n++) begin
            @(negedge clk);
            if (stepIdx != idx) begin
                done = 1;
            end
            else begin
                cur = {pwmC, pwmB, pwmA};
                for (int p = 0; p < 3; p++) begin
                    if (cur[p]) hiCnt[p]++;
                    if (cur[p] && !prev[p]) riseCnt[p]++;
                end
                prev = cur;
            end
        end
        if (!done) begin
            $display("timeout: a step did not end");
            otherErrors++;
        end
    endtask

    task automatic waitRiseA(output int cyc);
        logic prev;
        bit   seen;
        prev = pwmA;
        seen = 0;
        cyc  = 0;
        for (int n = 0; n < 5000 && !seen; n++) begin
            @(negedge clk);
            if (pwmA && !prev) begin
                seen = 1;
                cyc  = cycleCnt;
            end
            prev = pwmA;
        end
        if (!seen) begin
            $display("timeout: no rising edge on pwmA");
            otherErrors++;
        end
    endtask

    task automatic runLengthA(output int len);
        bit done;
        len  = 1;
        done = 0;
        for (int n = 0; n < 5000 && !done; n++) begin
            @(negedge clk);
            if (pwmA) len++;
            else done = 1;
        end
        if (!done) begin
            $display("timeout: pwmA stayed high");
            otherErrors++;
        end
    endtask

    initial begin
        int          t1;
        int          t2;
        int          runLen;
        int          perPulse;
        int          ticks;
        int          lens [3];
        logic [3:0]  idx;
        logic [15:0] want;

        clk    = 1'b0;
        arstN  = 1'b0;
        wrEn   = 1'b0;
        addr   = '0;
        wrData = '0;
        repeat (8) @(posedge clk);
        #5;
        arstN = 1'b1;

        // reset values, deficits included
        readCheck(3'd0, 511);
        readCheck(3'd1, 20000);
        for (int a = 2; a < 8; a++) readCheck(a[2:0], 0);

        // a whole step with every pulse length at zero
        writeReg(3'd1, 9999);
        waitStepChange();
        measureStep();
        if (riseCnt[0] + riseCnt[1] + riseCnt[2] != 0) begin
            $display("pwm pulsed while every pulse length was zero");
            otherErrors++;
        end

        // random lengths from 1 to 600 exercise the minimum width check
        for (int k = 0; k < 12; k++) begin
            for (int p = 0; p < 3; p++) begin
                writeReg(3'(2 + p), int'(randomBits(10)) % 600 + 1);
            end
            repeat (3000) @(negedge clk);
        end

        // accumulation of a short length into one pulse per few periods
        writeReg(3'd0, 600);
        writeReg(3'd2, 100);
        writeReg(3'd3, 0);
        writeReg(3'd4, 0);
        perPulse = (256 + 100 - 1) / 100;
        waitStepChange();
        for (int n = 0; n < 14 && (stepIdx == 4'd6 || stepIdx == 4'd11); n++) begin
            waitStepChange();
        end
        idx = stepIdx;
        waitRiseA(t1);
        runLengthA(runLen);
        if (runLen != perPulse * 100) begin
            $display("MISMATCH at %0t: pwmA run %0d, expected %0d",
                     $time, runLen, perPulse * 100);
            mismatches++;
        end
        waitRiseA(t2);
        if (t2 - t1 != perPulse * 600 || stepIdx != idx) begin
            $display("MISMATCH at %0t: pwmA pulse spacing %0d, expected %0d",
                     $time, t2 - t1, perPulse * 600);
            mismatches++;
        end

        // deficit after a full step with constant lengths
        lens[0] = 300;
        lens[1] = 200;
        lens[2] = 100;
        for (int p = 0; p < 3; p++) writeReg(3'(2 + p), lens[p]);
        waitStepChange();
        measureStep();
        // one tick per period before sliceStart plus the tick on the stepEnd cycle
        ticks = (9999 - 1) / 600 + 1;
        for (int p = 0; p < 3; p++) begin
            want = 16'(lens[p] * ticks - hiCnt[p]);
            readCheck(3'(5 + p), int'(want));
        end

        // gating in step 6, A is longer than B
        writeReg(3'd2, 500);
        writeReg(3'd3, 300);
        writeReg(3'd4, 300);
        waitStepChange();
        for (int n = 0; n < 14 && stepIdx != 4'd6; n++) begin
            waitStepChange();
        end
        measureStep();
        if (riseCnt[0] != 0) begin
            $display("pwmA pulsed during its gated step");
            otherErrors++;
        end
        if (riseCnt[1] == 0) begin
            $display("pwmB did not pulse during step 6");
            otherErrors++;
        end

        $display("done: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatches, otherErrors, i_motorDrive.i_motorDriveChk.failCount);
        if (mismatches == 0 && otherErrors == 0
            && i_motorDrive.i_motorDriveChk.failCount == 0) begin
            $display("PASS: all tests");
        end
        else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* testbench/motorDrive_chk.sv */
`timescale 1ns/1ps

module motorDriveChk (
    input logic                          clk,
    input logic                          arstN,
    input logic                          pwmA,
    input logic                          pwmB,
    input logic                          pwmC,
    input logic [motorPkg::STEP_W-1:0]   stepIdx,
    input logic [motorPkg::SLICE_W-1:0]  stepLen,
    input logic [motorPkg::LEN_W-1:0]    plLenA,
    input logic [motorPkg::LEN_W-1:0]    plLenB,
    input logic [motorPkg::LEN_W-1:0]    plLenC
);

    logic [motorPkg::LEN_W-1:0]   runA;
    logic [motorPkg::LEN_W-1:0]   runB;
    logic [motorPkg::LEN_W-1:0]   runC;
    logic [motorPkg::STEP_W-1:0]  idxQ;
    logic [motorPkg::SLICE_W-1:0] stepLenQ;
    logic [motorPkg::SLICE_W:0]   cycCnt;
    logic                         fullStep;
    int                           failCount = 0;

    // high-run counters, each holds the run length on the cycle pwm falls
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            runA <= '0;
            runB <= '0;
            runC <= '0;
        end
        else begin
            runA <= pwmA ? runA + 1'b1 : '0;
            runB <= pwmB ? runB + 1'b1 : '0;
            runC <= pwmC ? runC + 1'b1 : '0;
        end
    end

    // cycles spent in the current step, valid only if stepLen held still
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idxQ     <= '0;
            stepLenQ <= '0;
            cycCnt   <= '0;
            fullStep <= 1'b0;
        end
        else begin
            idxQ     <= stepIdx;
            stepLenQ <= stepLen;
            if (stepIdx != idxQ) begin
                cycCnt   <= 1;
                fullStep <= 1'b1;
            end
            else begin
                cycCnt <= cycCnt + 1'b1;
            end
            if (stepLen != stepLenQ) begin
                fullStep <= 1'b0;
            end
        end
    end

    resetQuiet: assert property (@(posedge clk)
        !arstN |-> (!pwmA && !pwmB && !pwmC && stepIdx == '0))
        else begin
            $error("outputs not idle during reset");
            failCount++;
        end

    silentA: assert property (@(posedge clk) disable iff (!arstN)
        $rose(pwmA) |-> $past(plLenA) != '0)
        else begin
            $error("pwmA rose with a zero pulse length");
            failCount++;
        end
    silentB: assert property (@(posedge clk) disable iff (!arstN)
        $rose(pwmB) |-> $past(plLenB) != '0)
        else begin
            $error("pwmB rose with a zero pulse length");
            failCount++;
        end
    silentC: assert property (@(posedge clk) disable iff (!arstN)
        $rose(pwmC) |-> $past(plLenC) != '0)
        else begin
            $error("pwmC rose with a zero pulse length");
            failCount++;
        end

    minWidthA: assert property (@(posedge clk) disable iff (!arstN)
        $fell(pwmA) |-> runA >= motorPkg::MIN_ON)
        else begin
            $error("pwmA pulse shorter than the minimum on-time");
            failCount++;
        end
    minWidthB: assert property (@(posedge clk) disable iff (!arstN)
        $fell(pwmB) |-> runB >= motorPkg::MIN_ON)
        else begin
            $error("pwmB pulse shorter than the minimum on-time");
            failCount++;
        end
    minWidthC: assert property (@(posedge clk) disable iff (!arstN)
        $fell(pwmC) |-> runC >= motorPkg::MIN_ON)
        else begin
            $error("pwmC pulse shorter than the minimum on-time");
            failCount++;
        end

    // the step index only ever moves forward by one and wraps after 11
    stepAdvance: assert property (@(posedge clk) disable iff (!arstN)
        (stepIdx != idxQ) |-> stepIdx == ((idxQ == 4'd11) ? 4'd0 : idxQ + 4'd1))
        else begin
            $error("step index did not advance by one");
            failCount++;
        end

    stepLength: assert property (@(posedge clk) disable iff (!arstN)
        (stepIdx != idxQ) && fullStep |-> cycCnt == {1'b0, stepLen} + 1'b1)
        else begin
            $error("step did not last stepLen+1 cycles");
            failCount++;
        end

endmodule

bind motorDrive motorDriveChk i_motorDriveChk (.*);

/* hw/motorDrive.sv */
`timescale 1ns/1ps

module motorDrive (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          wrEn,
    input  logic [motorPkg::ADDR_W-1:0]   addr,
    input  logic [motorPkg::DATA_W-1:0]   wrData,
    output logic [motorPkg::DATA_W-1:0]   rdData,
    output logic                          pwmA,
    output logic                          pwmB,
    output logic                          pwmC,
    output logic [motorPkg::STEP_W-1:0]   stepIdx
);

    logic [motorPkg::PWM_W-1:0]   periodLen;
    logic [motorPkg::SLICE_W-1:0] stepLen;
    logic [motorPkg::LEN_W-1:0]   plLenA;
    logic [motorPkg::LEN_W-1:0]   plLenB;
    logic [motorPkg::LEN_W-1:0]   plLenC;
    logic [motorPkg::LEN_W-1:0]   deficitA;
    logic [motorPkg::LEN_W-1:0]   deficitB;
    logic [motorPkg::LEN_W-1:0]   deficitC;
    logic [motorPkg::LEN_W-1:0]   sumA;
    logic [motorPkg::LEN_W-1:0]   sumB;
    logic [motorPkg::LEN_W-1:0]   sumC;
    logic                         sliceStart;
    logic                         stepEnd;

    motorRegs i_motorRegs (
        .clk, .arstN, .wrEn, .addr, .wrData, .rdData,
        .periodLen, .stepLen, .plLenA, .plLenB, .plLenC,
        .deficitA, .deficitB, .deficitC
    );

    stepSequencer i_stepSequencer (
        .clk, .arstN, .stepLen, .sliceStart, .stepEnd, .stepIdx
    );

    // the sums form a ring, next runs A to B to C to A and prev runs backwards
    pwmGenerator #(.phase(0)) i_pwmGenA (
        .clk, .arstN, .periodLen, .plLen(plLenA), .sliceStart, .stepEnd, .stepIdx,
        .sumNext(sumB), .sumPrev(sumC), .sumOut(sumA), .pwm(pwmA), .deficit(deficitA)
    );

    pwmGenerator #(.phase(1)) i_pwmGenB (
        .clk, .arstN, .periodLen, .plLen(plLenB), .sliceStart, .stepEnd, .stepIdx,
        .sumNext(sumC), .sumPrev(sumA), .sumOut(sumB), .pwm(pwmB), .deficit(deficitB)
    );

    pwmGenerator #(.phase(2)) i_pwmGenC (
        .clk, .arstN, .periodLen, .plLen(plLenC), .sliceStart, .stepEnd, .stepIdx,
        .sumNext(sumA), .sumPrev(sumB), .sumOut(sumC), .pwm(pwmC), .deficit(deficitC)
    );

endmodule

/* hw/motorRegs.sv */
`timescale 1ns/1ps

module motorRegs (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          wrEn,
    input  logic [motorPkg::ADDR_W-1:0]   addr,
    input  logic [motorPkg::DATA_W-1:0]   wrData,
    output logic [motorPkg::DATA_W-1:0]   rdData,
    output logic [motorPkg::PWM_W-1:0]    periodLen,
    output logic [motorPkg::SLICE_W-1:0]  stepLen,
    output logic [motorPkg::LEN_W-1:0]    plLenA,
    output logic [motorPkg::LEN_W-1:0]    plLenB,
    output logic [motorPkg::LEN_W-1:0]    plLenC,
    input  logic [motorPkg::LEN_W-1:0]    deficitA,
    input  logic [motorPkg::LEN_W-1:0]    deficitB,
    input  logic [motorPkg::LEN_W-1:0]    deficitC
);

    // writes keep only the low bits that fit each field
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            periodLen <= motorPkg::PERIOD_RST;
            stepLen   <= motorPkg::STEPLEN_RST;
            plLenA    <= '0;
            plLenB    <= '0;
            plLenC    <= '0;
        end
        else if (wrEn) begin
            case (addr)
                motorPkg::ADDR_PERIOD:  periodLen <= wrData[motorPkg::PWM_W-1:0];
                motorPkg::ADDR_STEPLEN: stepLen   <= wrData[motorPkg::SLICE_W-1:0];
                motorPkg::ADDR_LEN_A:   plLenA    <= wrData[motorPkg::LEN_W-1:0];
                motorPkg::ADDR_LEN_B:   plLenB    <= wrData[motorPkg::LEN_W-1:0];
                motorPkg::ADDR_LEN_C:   plLenC    <= wrData[motorPkg::LEN_W-1:0];
                default: begin
                    // deficit addresses ignore writes
                end
            endcase
        end
    end

    // readback is zero-extended, unused addresses read as 0
    always_comb begin
        rdData = '0;
        case (addr)
            motorPkg::ADDR_PERIOD:  rdData[motorPkg::PWM_W-1:0]   = periodLen;
            motorPkg::ADDR_STEPLEN: rdData[motorPkg::SLICE_W-1:0] = stepLen;
            motorPkg::ADDR_LEN_A:   rdData[motorPkg::LEN_W-1:0]   = plLenA;
            motorPkg::ADDR_LEN_B:   rdData[motorPkg::LEN_W-1:0]   = plLenB;
            motorPkg::ADDR_LEN_C:   rdData[motorPkg::LEN_W-1:0]   = plLenC;
            motorPkg::ADDR_DEF_A:   rdData[motorPkg::LEN_W-1:0]   = deficitA;
            motorPkg::ADDR_DEF_B:   rdData[motorPkg::LEN_W-1:0]   = deficitB;
            motorPkg::ADDR_DEF_C:   rdData[motorPkg::LEN_W-1:0]   = deficitC;
            default:                rdData = '0;
        endcase
    end

endmodule

/* pwm/pwmGenerator.sv */
`timescale 1ns/1ps

module pwmGenerator #(
    parameter int phase = 0
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [motorPkg::PWM_W-1:0]    periodLen,
    input  logic [motorPkg::LEN_W-1:0]    plLen,
    input  logic                          sliceStart,
    input  logic                          stepEnd,
    input  logic [motorPkg::STEP_W-1:0]   stepIdx,
    input  logic [motorPkg::LEN_W-1:0]    sumNext,
    input  logic [motorPkg::LEN_W-1:0]    sumPrev,
    output logic [motorPkg::LEN_W-1:0]    sumOut,
    output logic                          pwm,
    output logic [motorPkg::LEN_W-1:0]    deficit
);

    logic [motorPkg::PWM_W-1:0] periodCnt;
    logic                       reload;
    logic                       reloadQ;
    logic                       accTick;

    logic [motorPkg::LEN_W-1:0] remainder;
    logic [motorPkg::LEN_W-1:0] sum;
    logic [motorPkg::LEN_W-1:0] pulseCnt;
    logic                       ownGate;
    logic                       nextGate;
    logic                       gateOk;
    logic                       load;

    logic [motorPkg::LEN_W-1:0] wantAcc;
    logic [motorPkg::LEN_W-1:0] realAcc;
    logic [motorPkg::LEN_W-1:0] wantNow;
    logic [motorPkg::LEN_W-1:0] realNow;

    // period counter, held at reload while nothing is requested
    assign reload = sliceStart
                  | (periodCnt == motorPkg::PWM_W'(1))
                  | (plLen == '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            periodCnt <= '0;
            reloadQ   <= 1'b0;
        end
        else begin
            reloadQ <= reload;
            if (reload) begin
                periodCnt <= periodLen;
            end
            else begin
                periodCnt <= periodCnt - 1'b1;
            end
        end
    end

    // one tick per period, on the first cycle that follows a run of reloads
    assign accTick = reloadQ & ~reload;

    assign sum    = remainder + plLen;
    assign sumOut = sum;

    // in its own gated step a phase defers to the next phase, and in the next
    // phase's gated step it defers to the previous one
    assign ownGate  = (stepIdx == motorPkg::GATE_STEP[phase]);
    assign nextGate = (stepIdx == motorPkg::GATE_STEP[(phase + 1) % 3]);

    always_comb begin
        if (ownGate) begin
            gateOk = (sum <= sumNext);
        end
        else if (nextGate) begin
            gateOk = (sum <= sumPrev);
        end
        else begin
            gateOk = 1'b1;
        end
    end

    // sums shorter than the minimum on-time carry over to the next period
    assign load = accTick & gateOk & (sum >= motorPkg::MIN_ON);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            remainder <= '0;
        end
        else if (stepEnd) begin
            remainder <= '0;
        end
        else if (accTick) begin
            if (load) begin
                remainder <= '0;
            end
            else begin
                remainder <= sum;
            end
        end
    end

    // a new load restarts the pulse, so merged periods give one long run
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pulseCnt <= '0;
        end
        else if (load) begin
            pulseCnt <= sum;
        end
        else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    assign pwm = (pulseCnt != '0);

    // wanted and delivered on-time over the step, including its last cycle
    always_comb begin
        wantNow = wantAcc;
        if (accTick) begin
            wantNow = wantAcc + plLen;
        end
        realNow = realAcc + motorPkg::LEN_W'(pwm);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wantAcc <= '0;
            realAcc <= '0;
            deficit <= '0;
        end
        else if (stepEnd) begin
            deficit <= wantNow - realNow;
            wantAcc <= '0;
            realAcc <= '0;
        end
        else begin
            wantAcc <= wantNow;
            realAcc <= realNow;
        end
    end

endmodule

/* hw/stepSequencer.sv */
`timescale 1ns/1ps

module stepSequencer (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [motorPkg::SLICE_W-1:0]  stepLen,
    output logic                          sliceStart,
    output logic                          stepEnd,
    output logic [motorPkg::STEP_W-1:0]   stepIdx
);

    logic [motorPkg::SLICE_W-1:0] stepCnt;
    logic [motorPkg::SLICE_W-1:0] stepLenEff;
    logic                         lastStep;

    // a step of fewer than 3 cycles would merge sliceStart and stepEnd
    always_comb begin
        if (stepLen < motorPkg::SLICE_W'(2)) begin
            stepLenEff = motorPkg::SLICE_W'(2);
        end
        else begin
            stepLenEff = stepLen;
        end
    end

    // the counter runs from 0 up to stepLenEff, so a step lasts stepLenEff+1 cycles
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepCnt <= '0;
        end
        else if (stepEnd) begin
            stepCnt <= '0;
        end
        else begin
            stepCnt <= stepCnt + 1'b1;
        end
    end

    // sliceStart forces every period counter to reload one cycle before the
    // step ends, so each generator sees an accumulate tick on the stepEnd cycle
    assign sliceStart = (stepCnt == stepLenEff - 1'b1);

    // >= keeps the counter from running away if stepLen shrinks mid-step
    assign stepEnd = (stepCnt >= stepLenEff);

    assign lastStep = (stepIdx == motorPkg::STEP_W'(motorPkg::STEP_COUNT - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepIdx <= '0;
        end
        else if (stepEnd) begin
            if (lastStep) begin
                stepIdx <= '0;
            end
            else begin
                stepIdx <= stepIdx + 1'b1;
            end
        end
    end

endmodule

/* common/motorPkg.sv */
package motorPkg;

    // period length and period counter width
    localparam int PWM_W = 12;

    // pulse lengths, sums, remainders and deficits share one width
    localparam int LEN_W = 16;

    // step index, 12 commutation steps per electrical turn
    localparam int STEP_W = 4;
    localparam int STEP_COUNT = 12;

    // step-length counter, wide enough for long steps at 10 MHz
    localparam int SLICE_W = 25;

    // shortest gate pulse the power stage can follow, 25.6 us at 10 MHz
    localparam logic [LEN_W-1:0] MIN_ON = 16'd256;

    // step in which each phase is gated by its neighbour, indexed by phase
    // phase 0 in step 6, phase 1 in step 11, phase 2 in step 0
    localparam logic [2:0][STEP_W-1:0] GATE_STEP = {4'd0, 4'd11, 4'd6};

    // register port
    localparam int ADDR_W = 3;
    localparam int DATA_W = 25;

    localparam logic [ADDR_W-1:0] ADDR_PERIOD = 3'd0;
    localparam logic [ADDR_W-1:0] ADDR_STEPLEN = 3'd1;
    localparam logic [ADDR_W-1:0] ADDR_LEN_A = 3'd2;
    localparam logic [ADDR_W-1:0] ADDR_LEN_B = 3'd3;
    localparam logic [ADDR_W-1:0] ADDR_LEN_C = 3'd4;

    // deficit addresses are read only
    localparam logic [ADDR_W-1:0] ADDR_DEF_A = 3'd5;
    localparam logic [ADDR_W-1:0] ADDR_DEF_B = 3'd6;
    localparam logic [ADDR_W-1:0] ADDR_DEF_C = 3'd7;

    // register values after reset
    localparam logic [PWM_W-1:0] PERIOD_RST = 12'd511;
    localparam logic [SLICE_W-1:0] STEPLEN_RST = 25'd20000;

endpackage
